// ==== hdl/alert_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Alert handler package
// Class, severity and phase counts shared by all handler blocks,
// plus the class index type and the escalation state encoding
//////////////////////////////////////////////////////////////////////

package alert_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Number of alert classes
  parameter int unsigned N_CLASSES = 4;
  // Number of escalation severity outputs
  parameter int unsigned N_ESC_SEV = 4;
  // Escalation phases per class
  parameter int unsigned N_PHASES  = 4;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // Selects a class, and a severity in the escalation map
  typedef logic [1:0] class_idx_t;

  // Phase states are consecutive so the timer can step through them
  typedef enum logic [2:0] {
    ESC_IDLE     = 3'd0,
    ESC_TIMEOUT  = 3'd1,
    ESC_PHASE0   = 3'd2,
    ESC_PHASE1   = 3'd3,
    ESC_PHASE2   = 3'd4,
    ESC_PHASE3   = 3'd5,
    ESC_TERMINAL = 3'd6
  } esc_state_e;

endpackage

// ==== hdl/alert_intake.sv ====
//////////////////////////////////////////////////////////////////////
// Alert intake
// Registers incoming alert pulses under their enables and keeps a
// sticky cause bit per alert
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alert_intake #(
  parameter int unsigned NAlerts = 8
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [NAlerts-1:0] alert_i,
  input  logic [NAlerts-1:0] alert_en_i,
  input  logic [NAlerts-1:0] cause_clr_i,
  output logic [NAlerts-1:0] alert_trig_o,
  output logic [NAlerts-1:0] alert_cause_o
);

  logic [NAlerts-1:0] alert_masked;
  logic [NAlerts-1:0] alert_trig_q;
  logic [NAlerts-1:0] cause_q;

  // Disabled alerts are dropped before the register
  assign alert_masked = alert_i & alert_en_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      alert_trig_q <= '0;
    end else begin
      alert_trig_q <= alert_masked;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sticky cause bits
  //////////////////////////////////////////////////////////////////////

  // Set on the same edge as the trigger register, clear wins
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cause_q <= '0;
    end else begin
      cause_q <= (cause_q | alert_masked) & ~cause_clr_i;
    end
  end

  assign alert_trig_o  = alert_trig_q;
  assign alert_cause_o = cause_q;

endmodule

// ==== hdl/alert_class.sv ====
//////////////////////////////////////////////////////////////////////
// Alert classifier
// Routes triggered alerts onto their configured classes and turns
// class clears into per-alert cause clears
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alert_class
  import alert_pkg::*;
#(
  parameter int unsigned NAlerts = 8
) (
  input  logic       [NAlerts-1:0]   alert_trig_i,
  input  class_idx_t [NAlerts-1:0]   alert_class_i,
  input  logic       [N_CLASSES-1:0] class_clr_i,
  output logic       [N_CLASSES-1:0] class_trig_o,
  output logic       [NAlerts-1:0]   cause_clr_o
);

  // OR of all triggered alerts per class
  always_comb begin
    class_trig_o = '0;
    for (int k = 0; k < NAlerts; k++) begin
      if (alert_trig_i[k]) begin
        class_trig_o[alert_class_i[k]] = 1'b1;
      end
    end
  end

  // Same mapping, other direction
  always_comb begin
    for (int k = 0; k < NAlerts; k++) begin
      cause_clr_o[k] = class_clr_i[alert_class_i[k]];
    end
  end

endmodule

// ==== hdl/alert_accu.sv ====
//////////////////////////////////////////////////////////////////////
// Class accumulator
// Sticky class interrupt and saturating trigger count, flags a
// trigger that arrives with the count at or above the threshold
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alert_accu #(
  parameter int unsigned AccuCntDw = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 class_en_i,
  input  logic                 clr_i,
  input  logic                 class_trig_i,
  input  logic [AccuCntDw-1:0] thresh_i,
  output logic                 irq_o,
  output logic [AccuCntDw-1:0] accu_cnt_o,
  output logic                 accu_trig_o
);

  logic                 trig_en;
  logic                 irq_q;
  logic [AccuCntDw-1:0] cnt_q;

  assign trig_en = class_en_i & class_trig_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_q <= 1'b0;
      cnt_q <= '0;
    end else if (clr_i) begin
      irq_q <= 1'b0;
      cnt_q <= '0;
    end else if (trig_en) begin
      irq_q <= 1'b1;
      // Saturate at all ones
      if (cnt_q != {AccuCntDw{1'b1}}) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Compares the count before this trigger is added
  assign accu_trig_o = trig_en & ~clr_i & (cnt_q >= thresh_i);

  assign irq_o      = irq_q;
  assign accu_cnt_o = cnt_q;

endmodule

// ==== hdl/alert_esc_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Escalation timer
// Per-class FSM through an optional timeout and four escalation
// phases, with one severity request per phase from the map
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alert_esc_timer
  import alert_pkg::*;
#(
  parameter int unsigned EscCntDw = 16
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          class_en_i,
  input  logic                          clr_i,
  input  logic                          irq_i,
  input  logic                          accu_trig_i,
  input  logic       [EscCntDw-1:0]     timeout_cyc_i,
  input  logic       [EscCntDw-1:0]     phase_cyc_i,
  input  logic       [N_PHASES-1:0]     esc_en_i,
  input  class_idx_t [N_PHASES-1:0]     esc_map_i,
  output esc_state_e                    esc_state_o,
  output logic       [N_ESC_SEV-1:0]    esc_req_o
);

  localparam int unsigned PhaseIdxW = $clog2(N_PHASES);

  esc_state_e            state_q, state_d;
  logic [EscCntDw-1:0]   cnt_q, cnt_d;
  logic [EscCntDw-1:0]   cnt_limit;
  logic [EscCntDw:0]     cnt_inc;
  logic                  cnt_last;
  logic [2:0]            phase_off;
  logic [PhaseIdxW-1:0]  phase_idx;
  logic                  phase_act;

  //////////////////////////////////////////////////////////////////////
  // Shared cycle counter
  //////////////////////////////////////////////////////////////////////

  // Timeout length first, then the phase length
  assign cnt_limit = (state_q == ESC_TIMEOUT) ? timeout_cyc_i : phase_cyc_i;
  // One bit wider so a zero limit never wraps
  assign cnt_inc   = {1'b0, cnt_q} + 1'b1;
  assign cnt_last  = cnt_inc >= {1'b0, cnt_limit};

  always_comb begin
    state_d = state_q;
    cnt_d   = '0;
    if (clr_i) begin
      state_d = ESC_IDLE;
    end else begin
      unique case (state_q)
        ESC_IDLE: begin
          if (accu_trig_i) begin
            state_d = ESC_PHASE0;
          end else if (class_en_i && irq_i && (timeout_cyc_i != '0)) begin
            state_d = ESC_TIMEOUT;
          end
        end
        ESC_TIMEOUT: begin
          cnt_d = cnt_q + 1'b1;
          // Threshold hit cuts the timeout short
          if (accu_trig_i || cnt_last) begin
            state_d = ESC_PHASE0;
            cnt_d   = '0;
          end
        end
        ESC_PHASE0, ESC_PHASE1, ESC_PHASE2, ESC_PHASE3: begin
          cnt_d = cnt_q + 1'b1;
          if (cnt_last) begin
            // Phase3 steps into terminal
            state_d = esc_state_e'(state_q + 3'd1);
            cnt_d   = '0;
          end
        end
        ESC_TERMINAL: begin
          state_d = ESC_TERMINAL;
        end
        default: begin
          state_d = ESC_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ESC_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Phase request decode
  //////////////////////////////////////////////////////////////////////

  assign phase_act = (state_q >= ESC_PHASE0);
  assign phase_off = state_q - ESC_PHASE0;

  // Terminal keeps the last phase
  always_comb begin
    phase_idx = phase_off[PhaseIdxW-1:0];
    if (state_q == ESC_TERMINAL) begin
      phase_idx = PhaseIdxW'(N_PHASES - 1);
    end
  end

  always_comb begin
    esc_req_o = '0;
    if (phase_act && esc_en_i[phase_idx]) begin
      esc_req_o[esc_map_i[phase_idx]] = 1'b1;
    end
  end

  assign esc_state_o = state_q;

endmodule

// ==== hdl/alert_esc_out.sv ====
//////////////////////////////////////////////////////////////////////
// Escalation combiner
// ORs the class requests per severity and registers the result
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alert_esc_out
  import alert_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [N_CLASSES-1:0][N_ESC_SEV-1:0] class_esc_req_i,
  output logic [N_ESC_SEV-1:0]                esc_o
);

  logic [N_ESC_SEV-1:0][N_CLASSES-1:0] req_trsp;
  logic [N_ESC_SEV-1:0]                esc_d;
  logic [N_ESC_SEV-1:0]                esc_q;

  // Severity-major view of the request matrix
  for (genvar s = 0; s < N_ESC_SEV; s++) begin : gen_sev
    for (genvar c = 0; c < N_CLASSES; c++) begin : gen_trsp
      assign req_trsp[s][c] = class_esc_req_i[c][s];
    end

    // Any class asking for this severity
    assign esc_d[s] = |req_trsp[s];
  end

  // Output flops keep decode glitches off the pins
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      esc_q <= '0;
    end else begin
      esc_q <= esc_d;
    end
  end

  assign esc_o = esc_q;

endmodule

// ==== hdl/alert_handler.sv ====
//////////////////////////////////////////////////////////////////////
// Alert handler top
// Alert intake, class routing, per-class accumulation and escalation
// timing, and the severity output combiner
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alert_handler
  import alert_pkg::*;
#(
  parameter int unsigned NAlerts   = 8,
  parameter int unsigned AccuCntDw = 16,
  parameter int unsigned EscCntDw  = 16
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic       [NAlerts-1:0]              alert_i,
  input  logic       [NAlerts-1:0]              alert_en_i,
  input  class_idx_t [NAlerts-1:0]              alert_class_i,
  input  logic       [N_CLASSES-1:0]            class_en_i,
  input  logic       [N_CLASSES-1:0]            class_clr_i,
  input  logic       [N_CLASSES-1:0][AccuCntDw-1:0] class_thresh_i,
  input  logic       [N_CLASSES-1:0][EscCntDw-1:0]  class_timeout_cyc_i,
  input  logic       [N_CLASSES-1:0][EscCntDw-1:0]  class_phase_cyc_i,
  input  logic       [N_CLASSES-1:0][N_PHASES-1:0]  class_esc_en_i,
  input  class_idx_t [N_CLASSES-1:0][N_PHASES-1:0]  class_esc_map_i,
  output logic       [N_CLASSES-1:0]            irq_o,
  output logic       [NAlerts-1:0]              alert_cause_o,
  output logic       [N_CLASSES-1:0][AccuCntDw-1:0] class_accu_cnt_o,
  output esc_state_e [N_CLASSES-1:0]            class_esc_state_o,
  output logic       [N_ESC_SEV-1:0]            esc_o
);

  logic [NAlerts-1:0]                  alert_trig;
  logic [NAlerts-1:0]                  cause_clr;
  logic [N_CLASSES-1:0]                class_trig;
  logic [N_CLASSES-1:0]                accu_trig;
  logic [N_CLASSES-1:0][N_ESC_SEV-1:0] class_esc_req;

  //////////////////////////////////////////////////////////////////////
  // Intake and classification
  //////////////////////////////////////////////////////////////////////

  alert_intake #(
    .NAlerts(NAlerts)
  ) u_intake (
    .clk_i,
    .rst_n_i,
    .alert_i       ( alert_i       ),
    .alert_en_i    ( alert_en_i    ),
    .cause_clr_i   ( cause_clr     ),
    .alert_trig_o  ( alert_trig    ),
    .alert_cause_o ( alert_cause_o )
  );

  alert_class #(
    .NAlerts(NAlerts)
  ) u_class (
    .alert_trig_i  ( alert_trig    ),
    .alert_class_i ( alert_class_i ),
    .class_clr_i   ( class_clr_i   ),
    .class_trig_o  ( class_trig    ),
    .cause_clr_o   ( cause_clr     )
  );

  //////////////////////////////////////////////////////////////////////
  // Per-class accumulation and escalation
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < N_CLASSES; k++) begin : gen_classes
    alert_accu #(
      .AccuCntDw(AccuCntDw)
    ) u_accu (
      .clk_i,
      .rst_n_i,
      .class_en_i   ( class_en_i[k]       ),
      .clr_i        ( class_clr_i[k]      ),
      .class_trig_i ( class_trig[k]       ),
      .thresh_i     ( class_thresh_i[k]   ),
      .irq_o        ( irq_o[k]            ),
      .accu_cnt_o   ( class_accu_cnt_o[k] ),
      .accu_trig_o  ( accu_trig[k]        )
    );

    // Trigger term lets the timeout start on the edge that sets irq
    alert_esc_timer #(
      .EscCntDw(EscCntDw)
    ) u_esc_timer (
      .clk_i,
      .rst_n_i,
      .class_en_i    ( class_en_i[k]                ),
      .clr_i         ( class_clr_i[k]               ),
      .irq_i         ( irq_o[k] | class_trig[k]     ),
      .accu_trig_i   ( accu_trig[k]                 ),
      .timeout_cyc_i ( class_timeout_cyc_i[k]       ),
      .phase_cyc_i   ( class_phase_cyc_i[k]         ),
      .esc_en_i      ( class_esc_en_i[k]            ),
      .esc_map_i     ( class_esc_map_i[k]           ),
      .esc_state_o   ( class_esc_state_o[k]         ),
      .esc_req_o     ( class_esc_req[k]             )
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Severity outputs
  //////////////////////////////////////////////////////////////////////

  alert_esc_out u_esc_out (
    .clk_i,
    .rst_n_i,
    .class_esc_req_i ( class_esc_req ),
    .esc_o           ( esc_o         )
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// Free-running clock and a reset held low for the first cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PeriodNs    = 4,
  parameter int ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Released just after an edge, like the other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== testbench/alert_handler_chk.sv ====
//////////////////////////////////////////////////////////////////////
// Alert handler checker
// Concurrent assertions on the top level outputs, bound to the DUT
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alert_handler_chk
  import alert_pkg::*;
#(
  parameter int unsigned NAlerts   = 8,
  parameter int unsigned AccuCntDw = 16
) (
  input logic                                clk_i,
  input logic                                rst_n_i,
  input logic       [N_CLASSES-1:0]          class_trig_i,
  input logic       [N_CLASSES-1:0]          irq_i,
  input logic       [NAlerts-1:0]            alert_cause_i,
  input logic [N_CLASSES-1:0][AccuCntDw-1:0] accu_cnt_i,
  input esc_state_e [N_CLASSES-1:0]          esc_state_i,
  input logic       [N_ESC_SEV-1:0]          esc_i
);

  logic all_idle;
  logic known_err = 1'b0;
  logic idle_err  = 1'b0;
  logic irq_err   = 1'b0;
  logic assert_fail;

  always_comb begin
    all_idle = 1'b1;
    for (int k = 0; k < N_CLASSES; k++) begin
      if (esc_state_i[k] != ESC_IDLE) begin
        all_idle = 1'b0;
      end
    end
  end

  a_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown({irq_i, alert_cause_i, accu_cnt_i, esc_state_i, esc_i}))
    else begin
      $error("Unknown value on an alert handler output");
      known_err = 1'b1;
    end

  // Output register lags the states by one cycle
  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (all_idle && $past(all_idle)) |-> (esc_i == '0))
    else begin
      $error("Escalation output active with all classes idle");
      idle_err = 1'b1;
    end

  a_irq_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (irq_i & ~$past(irq_i) & ~$past(class_trig_i)) == '0)
    else begin
      $error("Class interrupt rose without a class trigger");
      irq_err = 1'b1;
    end

  assign assert_fail = known_err | idle_err | irq_err;

endmodule

bind alert_handler alert_handler_chk #(
  .NAlerts   ( NAlerts   ),
  .AccuCntDw ( AccuCntDw )
) u_chk (
  .clk_i         ( clk_i             ),
  .rst_n_i       ( rst_n_i           ),
  .class_trig_i  ( class_trig        ),
  .irq_i         ( irq_o             ),
  .alert_cause_i ( alert_cause_o     ),
  .accu_cnt_i    ( class_accu_cnt_o  ),
  .esc_state_i   ( class_esc_state_o ),
  .esc_i         ( esc_o             )
);

// ==== testbench/alert_handler_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Alert handler testbench
// Directed tests for intake, accumulation, phase timing, timeout
// and severity combining
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alert_handler_tb
  import alert_pkg::*;
();

  localparam int unsigned NAlerts   = 8;
  localparam int unsigned AccuCntDw = 16;
  localparam int unsigned EscCntDw  = 16;
  // Limit well above the few hundred cycles the tests take
  localparam int MaxCycles = 5000;

  logic                                  clk;
  logic                                  rst_n;
  logic       [NAlerts-1:0]              alert;
  logic       [NAlerts-1:0]              alert_en;
  class_idx_t [NAlerts-1:0]              alert_class;
  logic       [N_CLASSES-1:0]            class_en;
  logic       [N_CLASSES-1:0]            class_clr;
  logic [N_CLASSES-1:0][AccuCntDw-1:0]   class_thresh;
  logic [N_CLASSES-1:0][EscCntDw-1:0]    class_timeout;
  logic [N_CLASSES-1:0][EscCntDw-1:0]    class_phase;
  logic [N_CLASSES-1:0][N_PHASES-1:0]    class_esc_en;
  class_idx_t [N_CLASSES-1:0][N_PHASES-1:0] class_esc_map;
  logic       [N_CLASSES-1:0]            irq;
  logic       [NAlerts-1:0]              alert_cause;
  logic [N_CLASSES-1:0][AccuCntDw-1:0]   accu_cnt;
  esc_state_e [N_CLASSES-1:0]            esc_state;
  logic       [N_ESC_SEV-1:0]            esc;
  int                                    cycles = 0;

  tb_clock_gen u_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  alert_handler DUT (
    .clk_i               ( clk           ),
    .rst_n_i             ( rst_n         ),
    .alert_i             ( alert         ),
    .alert_en_i          ( alert_en      ),
    .alert_class_i       ( alert_class   ),
    .class_en_i          ( class_en      ),
    .class_clr_i         ( class_clr     ),
    .class_thresh_i      ( class_thresh  ),
    .class_timeout_cyc_i ( class_timeout ),
    .class_phase_cyc_i   ( class_phase   ),
    .class_esc_en_i      ( class_esc_en  ),
    .class_esc_map_i     ( class_esc_map ),
    .irq_o               ( irq           ),
    .alert_cause_o       ( alert_cause   ),
    .class_accu_cnt_o    ( accu_cnt      ),
    .class_esc_state_o   ( esc_state     ),
    .esc_o               ( esc           )
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers and compare tasks
  //////////////////////////////////////////////////////////////////////

  // Inputs change and outputs are read 1 ns after the edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic report_error(string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      report_error($sformatf("Fail at %0t: %s expected %0b got %0b", $time, name, exp, act));
    end
  endtask

  task automatic check_cnt(string name, logic [AccuCntDw-1:0] exp, logic [AccuCntDw-1:0] act);
    if (act !== exp) begin
      report_error($sformatf("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_state(string name, esc_state_e exp, esc_state_e act);
    if (act !== exp) begin
      report_error($sformatf("Fail at %0t: %s expected %s got %s",
                             $time, name, exp.name(), act.name()));
    end
  endtask

  task automatic check_vec(string name, logic [NAlerts-1:0] exp, logic [NAlerts-1:0] act);
    if (act !== exp) begin
      report_error($sformatf("Fail at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  function automatic logic [N_ESC_SEV-1:0] sev_bit(class_idx_t sev);
    logic [N_ESC_SEV-1:0] r;
    r      = '0;
    r[sev] = 1'b1;
    return r;
  endfunction

  // Request of class c in phase p where -1 means idle and 4 terminal
  function automatic logic [N_ESC_SEV-1:0] phase_req(int c, int p);
    int idx;
    idx = (p > 3) ? 3 : p;
    if (p < 0 || !class_esc_en[c][idx]) begin
      return '0;
    end
    return sev_bit(class_esc_map[c][idx]);
  endfunction

  function automatic esc_state_e phase_state(int p);
    case (p)
      0: return ESC_PHASE0;
      1: return ESC_PHASE1;
      2: return ESC_PHASE2;
      3: return ESC_PHASE3;
      default: return ESC_TERMINAL;
    endcase
  endfunction

  // Classes hit by a set of registered alerts
  function automatic logic [N_CLASSES-1:0] expected_irq(logic [NAlerts-1:0] trig);
    logic [N_CLASSES-1:0] r;
    r = '0;
    for (int k = 0; k < NAlerts; k++) begin
      if (trig[k] && class_en[alert_class[k]]) begin
        r[alert_class[k]] = 1'b1;
      end
    end
    return r;
  endfunction

  task automatic set_defaults();
    alert       = '0;
    alert_en    = '1;
    alert_class = '0;
    class_en    = '1;
    class_clr   = '0;
    for (int c = 0; c < N_CLASSES; c++) begin
      class_thresh[c]  = '1;
      class_timeout[c] = '0;
      class_phase[c]   = EscCntDw'(1);
      class_esc_en[c]  = '1;
      class_esc_map[c] = '0;
    end
  endtask

  task automatic clear_all();
    class_clr = '1;
    step();
    class_clr = '0;
    step();
  endtask

  task automatic pulse_alerts(logic [NAlerts-1:0] a);
    alert = a;
    step();
    alert = '0;
  endtask

  // Single pulse per class, so each count is 0 or 1
  task automatic check_classes(logic [N_CLASSES-1:0] irq_exp);
    check_vec("irq_o", NAlerts'(irq_exp), NAlerts'(irq));
    for (int c = 0; c < N_CLASSES; c++) begin
      check_cnt($sformatf("class_accu_cnt_o[%0d]", c), AccuCntDw'(irq_exp[c]), accu_cnt[c]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_vec("irq_o", '0, NAlerts'(irq));
    check_vec("alert_cause_o", '0, alert_cause);
    check_vec("esc_o", '0, NAlerts'(esc));
    for (int c = 0; c < N_CLASSES; c++) begin
      check_cnt($sformatf("class_accu_cnt_o[%0d]", c), '0, accu_cnt[c]);
      check_state($sformatf("class_esc_state_o[%0d]", c), ESC_IDLE, esc_state[c]);
    end
  endtask

  task automatic test_causes();
    logic [NAlerts-1:0]   a;
    logic [NAlerts-1:0]   cause_exp;
    logic [N_CLASSES-1:0] irq_exp;
    int                   c;
    set_defaults();
    a        = NAlerts'($urandom());
    alert_en = NAlerts'($urandom());
    for (int k = 0; k < NAlerts; k++) begin
      alert_class[k] = class_idx_t'($urandom_range(3, 0));
    end
    cause_exp = a & alert_en;
    irq_exp   = expected_irq(cause_exp);
    pulse_alerts(a);
    check_vec("alert_cause_o", cause_exp, alert_cause);
    step();
    check_classes(irq_exp);
    // Clear one class only
    c            = int'($urandom_range(3, 0));
    class_clr[c] = 1'b1;
    step();
    class_clr[c] = 1'b0;
    irq_exp[c]   = 1'b0;
    for (int k = 0; k < NAlerts; k++) begin
      if (alert_class[k] == class_idx_t'(c)) begin
        cause_exp[k] = 1'b0;
      end
    end
    check_vec("alert_cause_o", cause_exp, alert_cause);
    check_classes(irq_exp);
    clear_all();
    // Disabled class ignores its alerts
    c                = int'($urandom_range(3, 0));
    alert_en         = '1;
    class_en[c]      = 1'b0;
    class_thresh[c]  = '0;
    class_timeout[c] = EscCntDw'(4);
    alert_class      = {NAlerts{class_idx_t'(c)}};
    pulse_alerts('1);
    step();
    check_bit($sformatf("irq_o[%0d]", c), 1'b0, irq[c]);
    check_cnt($sformatf("class_accu_cnt_o[%0d]", c), '0, accu_cnt[c]);
    check_state($sformatf("class_esc_state_o[%0d]", c), ESC_IDLE, esc_state[c]);
  endtask

  task automatic test_accumulate();
    int c;
    int thr;
    set_defaults();
    c   = int'($urandom_range(3, 0));
    thr = 3;
    alert_class[0]  = class_idx_t'(c);
    class_thresh[c] = AccuCntDw'(thr);
    class_phase[c]  = EscCntDw'(100);
    for (int p = 0; p < N_PHASES; p++) begin
      class_esc_map[c][p] = class_idx_t'($urandom_range(3, 0));
    end
    for (int n = 1; n <= thr; n++) begin
      pulse_alerts(NAlerts'(1));
      step();
      check_cnt("class_accu_cnt_o", AccuCntDw'(n), accu_cnt[c]);
      check_state("class_esc_state_o", ESC_IDLE, esc_state[c]);
    end
    // This pulse finds the count at the threshold
    pulse_alerts(NAlerts'(1));
    step();
    check_cnt("class_accu_cnt_o", AccuCntDw'(thr + 1), accu_cnt[c]);
    check_state("class_esc_state_o", ESC_PHASE0, esc_state[c]);
    check_vec("esc_o", '0, NAlerts'(esc));
    step();
    check_vec("esc_o", NAlerts'(sev_bit(class_esc_map[c][0])), NAlerts'(esc));
  endtask

  task automatic test_phase_walk();
    int c;
    int plen;
    int prev;
    set_defaults();
    c    = int'($urandom_range(3, 0));
    plen = int'($urandom_range(5, 2));
    alert_class[0]  = class_idx_t'(c);
    class_thresh[c] = '0;
    class_phase[c]  = EscCntDw'(plen);
    // Phase 2 drives nothing
    class_esc_en[c] = 4'b1011;
    for (int p = 0; p < N_PHASES; p++) begin
      class_esc_map[c][p] = class_idx_t'($urandom_range(3, 0));
    end
    pulse_alerts(NAlerts'(1));
    step();
    // t counts cycles since the class entered phase 0
    for (int t = 0; t < 4 * plen + 3; t++) begin
      prev = (t == 0) ? -1 : (t - 1) / plen;
      check_state("class_esc_state_o", phase_state(t / plen), esc_state[c]);
      check_vec("esc_o", NAlerts'(phase_req(c, prev)), NAlerts'(esc));
      step();
    end
    class_clr[c] = 1'b1;
    step();
    class_clr[c] = 1'b0;
    check_state("class_esc_state_o", ESC_IDLE, esc_state[c]);
    check_vec("esc_o", NAlerts'(phase_req(c, 3)), NAlerts'(esc));
    step();
    check_vec("esc_o", '0, NAlerts'(esc));
  endtask

  task automatic test_timeout();
    int c;
    int tmo;
    set_defaults();
    c   = int'($urandom_range(3, 0));
    tmo = int'($urandom_range(8, 3));
    alert_class[0]   = class_idx_t'(c);
    class_thresh[c]  = AccuCntDw'(5);
    class_timeout[c] = EscCntDw'(tmo);
    class_phase[c]   = EscCntDw'(100);
    for (int p = 0; p < N_PHASES; p++) begin
      class_esc_map[c][p] = class_idx_t'($urandom_range(3, 0));
    end
    pulse_alerts(NAlerts'(1));
    step();
    for (int t = 0; t < tmo; t++) begin
      check_state("class_esc_state_o", ESC_TIMEOUT, esc_state[c]);
      check_vec("esc_o", '0, NAlerts'(esc));
      step();
    end
    check_state("class_esc_state_o", ESC_PHASE0, esc_state[c]);
    step();
    check_vec("esc_o", NAlerts'(sev_bit(class_esc_map[c][0])), NAlerts'(esc));
    clear_all();
    // Clear in the middle of the timeout
    pulse_alerts(NAlerts'(1));
    step();
    check_state("class_esc_state_o", ESC_TIMEOUT, esc_state[c]);
    step();
    class_clr[c] = 1'b1;
    step();
    class_clr[c] = 1'b0;
    for (int t = 0; t < tmo + 2; t++) begin
      check_state("class_esc_state_o", ESC_IDLE, esc_state[c]);
      check_vec("esc_o", '0, NAlerts'(esc));
      step();
    end
  endtask

  task automatic test_combine();
    int                   ca;
    int                   cb;
    class_idx_t           sa;
    class_idx_t           sb;
    logic [N_ESC_SEV-1:0] esc_exp;
    // Round 0 shares one severity, round 1 uses two
    for (int r = 0; r < 2; r++) begin
      set_defaults();
      ca = int'($urandom_range(3, 0));
      cb = (ca + 1) % 4;
      sa = class_idx_t'($urandom_range(3, 0));
      sb = (r == 0) ? sa : sa + 2'd1;
      alert_class[0]       = class_idx_t'(ca);
      alert_class[1]       = class_idx_t'(cb);
      class_thresh[ca]     = '0;
      class_thresh[cb]     = '0;
      class_phase[ca]      = EscCntDw'(100);
      class_phase[cb]      = EscCntDw'(100);
      class_esc_map[ca][0] = sa;
      class_esc_map[cb][0] = sb;
      esc_exp = sev_bit(sa) | sev_bit(sb);
      pulse_alerts(NAlerts'(3));
      step();
      check_state("class_esc_state_o[a]", ESC_PHASE0, esc_state[ca]);
      check_state("class_esc_state_o[b]", ESC_PHASE0, esc_state[cb]);
      step();
      check_vec("esc_o", NAlerts'(esc_exp), NAlerts'(esc));
      clear_all();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(50));
    set_defaults();
    @(posedge rst_n);
    step();
    test_reset();
    clear_all();
    test_causes();
    clear_all();
    test_accumulate();
    clear_all();
    test_phase_walk();
    clear_all();
    test_timeout();
    clear_all();
    test_combine();
    if (DUT.u_chk.assert_fail) begin
      $display("A checker assertion failed during the run");
      $display("Test failures found");
      $fatal(1, "Simulation stopped on assertion failure");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      report_error($sformatf("Run did not finish within %0d cycles", MaxCycles));
    end else if (DUT.u_chk.assert_fail) begin
      report_error("A checker assertion failed");
    end
  end

endmodule

// ==== alert_handler.f ====
hdl/alert_pkg.sv
hdl/alert_intake.sv
hdl/alert_class.sv
hdl/alert_accu.sv
hdl/alert_esc_timer.sv
hdl/alert_esc_out.sv
hdl/alert_handler.sv
testbench/tb_clock_gen.sv
testbench/alert_handler_chk.sv
testbench/alert_handler_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the alert handler testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f alert_handler.f --top-module alert_handler_tb -o alert_handler_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Error limit lets checker assertions reach the testbench
output=$(./obj_dir/alert_handler_sim +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF 'All tests passed!' <<< "$output"; then
  exit 0
fi
echo "Pass message not found"
exit 1
